// File: sim.f
nocPkg.sv
portIf.sv
inputPort.sv
portTimer.sv
switchArbiter.sv
crossbarMux.sv
nocSwitch.sv
switchTb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module switchTb -f sim.f -o switchSim \
  && ./obj_dir/switchSim | tee sim.log \
  || { echo "Build or run of the simulation failed"; exit 1; }
grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

// File: switchTb.sv
module switchTb;

  timeunit 1ns;
  timeprecision 100ps;

  import nocPkg::*;

  // The watchdog sums these per-test cycle budgets.
  localparam int RESET_CYCLES = 8;
  localparam int PRIO_CYCLES = 12;
  localparam int HOLD_CYCLES = 32;
  localparam int ROT_CYCLES = 28;
  localparam int EARLY_CYCLES = 16;
  localparam int DATA_CYCLES = 90;
  localparam int RUN_CYCLES = RESET_CYCLES + PRIO_CYCLES + HOLD_CYCLES + ROT_CYCLES
    + EARLY_CYCLES + DATA_CYCLES;

  logic clk;
  logic rst;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] inFlit;
  logic [NUM_PORTS-1:0] inReq;
  logic [FLIT_W-1:0] outFlit;
  logic outValid;
  logic [NUM_PORTS-1:0] grant;

  int mHolder; // Port holding the model grant or -1 when idle.
  int mCount [NUM_PORTS];
  int mLimit [NUM_PORTS];
  portVec_t mReq;
  portVec_t upVec;
  flitWord_t mFlit [NUM_PORTS];
  portVec_t expGrant;
  logic expValid;
  flitWord_t expFlit;

  string testName;
  int testsRun = 0;
  int testsFailed = 0;
  int procErrors = 0;
  int checkErrors = 0;
  int procBase = 0;
  int checkBase = 0;

  nocSwitch uut
  (
    .clk(clk),
    .rst(rst),
    .inFlit(inFlit),
    .inReq(inReq),
    .outFlit(outFlit),
    .outValid(outValid),
    .grant(grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    repeat (RUN_CYCLES + 200) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  function automatic portVec_t onlyPort(input int p);
    portVec_t v;
    v = '0;
    v[p] = 1'b1;
    return v;
  endfunction

  function automatic logic [FLIT_W-1:0] makeFlit(input logic [ID_W-1:0] id,
                                                 input logic [FLIT_W-ID_W-1:0] bits);
    return {id, bits};
  endfunction

  function automatic logic [FLIT_W-1:0] randomFlit();
    logic [ID_W-1:0] id;
    id = 3'($urandom % 4);
    if (id == FLIT_HEAD)
      return makeFlit(id, {1'b0, 12'($urandom % 8)}); // Keep random holds short.
    return makeFlit(id, 13'($urandom));
  endfunction

  // Holder keeps the switch while it asks and has time left, else the rotation moves on.
  function automatic int nextHolder(input int holder, input portVec_t reqs, input portVec_t up);
    int result;
    int idx;
    result = -1;
    if (holder >= 0 && reqs[holder] && !up[holder])
      result = holder;
    else
    begin
      for (int step = 1; step <= NUM_PORTS; step++)
      begin
        idx = (holder < 0) ? step - 1 : (holder + step) % NUM_PORTS;
        if (result < 0 && idx != holder && reqs[idx])
          result = idx;
      end
    end
    return result;
  endfunction

  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
      upVec[i] = (mCount[i] == mLimit[i]);
    expGrant = (mHolder < 0) ? '0 : onlyPort(mHolder);
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      mHolder <= -1;
      mReq <= '0;
      expValid <= 1'b0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        mFlit[i] <= '0;
        mCount[i] <= 0;
        mLimit[i] <= 0;
      end
    end
    else
    begin
      mHolder <= nextHolder(mHolder, mReq, upVec);
      mReq <= inReq;
      expValid <= (mHolder >= 0);
      if (mHolder >= 0)
        expFlit <= mFlit[mHolder]; // Output lags the grant by one edge.
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        mFlit[i] <= inFlit[i];
        if (mFlit[i].head.id == FLIT_HEAD)
          mLimit[i] <= int'(mFlit[i].head.length);
        if (i == mHolder && mReq[i] && !upVec[i])
          mCount[i] <= mCount[i] + 1;
        else
          mCount[i] <= 0;
      end
    end
  end

  task automatic showMismatch(input string what, input logic [FLIT_W-1:0] want,
                              input logic [FLIT_W-1:0] got);
    $display("** Error [%s] %s: expected %h, actual %h", testName, what, want, got);
  endtask

  // Outputs settle well before the falling edge.
  assert property (@(negedge clk) grant === expGrant)
  else
  begin
    checkErrors++;
    showMismatch("grant", 16'(expGrant), 16'(grant));
  end

  assert property (@(negedge clk) outValid === expValid)
  else
  begin
    checkErrors++;
    showMismatch("outValid", 16'(expValid), 16'(outValid));
  end

  assert property (@(negedge clk) expValid |-> outFlit === expFlit)
  else
  begin
    checkErrors++;
    showMismatch("outFlit", expFlit, outFlit);
  end

  task automatic cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic stateError(input string msg);
    procErrors++;
    $display("Test %s: %s", testName, msg);
  endtask

  task automatic expectWord(input string what, input logic [FLIT_W-1:0] want,
                            input logic [FLIT_W-1:0] got);
    assert (got === want)
    else
    begin
      procErrors++;
      showMismatch(what, want, got);
    end
  endtask

  task automatic expectGrantStep(input int p);
    portVec_t want;
    want = (p < 0) ? '0 : onlyPort(p);
    expectWord("grant", 16'(want), 16'(grant));
    cycle();
  endtask

  task automatic releaseAll();
    inReq = '0;
    repeat (4) cycle();
  endtask

  task automatic startTest(input string name);
    testName = name;
    testsRun++;
    procBase = procErrors;
    checkBase = checkErrors;
  endtask

  task automatic endTest();
    int errs;
    errs = (procErrors - procBase) + (checkErrors - checkBase);
    if (errs == 0)
      $display("Test %s passed", testName);
    else
    begin
      testsFailed++;
      $display("Test %s failed with %0d mismatches", testName, errs);
    end
  endtask

  // E holds against W for n+1 cycles, then W takes over.
  task automatic timedHold(input int n);
    int held;
    held = 0;
    inFlit[PORT_E] = makeFlit(FLIT_HEAD, {1'b0, 12'(n)});
    inReq[PORT_E] = 1'b1;
    inReq[PORT_W] = 1'b1;
    cycle();
    inFlit[PORT_E] = makeFlit(FLIT_BODY, 13'($urandom));
    cycle();
    while (grant[PORT_E] && held <= n + 2)
    begin
      held++;
      inFlit[PORT_E] = makeFlit(FLIT_BODY, 13'($urandom));
      cycle();
    end
    expectWord("E hold cycles", 16'(n + 1), 16'(held));
    expectWord("grant after E", 16'(onlyPort(PORT_W)), 16'(grant));
    releaseAll();
  endtask

  initial
  begin
    int validSeen;
    int headSeen;
    int bodySeen;
    void'($urandom(42249));
    rst = 1'b1;
    inReq = '0;
    inFlit = '0;

    startTest("reset");
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    cycle();
    cycle();
    if (grant != '0 || outValid)
      stateError("grant or outValid was set just after reset");
    endTest();

    startTest("priority");
    inReq = '1;
    cycle();
    expectGrantStep(-1); // Request is only registered so far.
    expectGrantStep(PORT_L);
    releaseAll();
    endTest();

    startTest("timed hold");
    timedHold(int'($urandom % 6) + 1);
    timedHold(0);
    endTest();

    startTest("rotation");
    inReq = onlyPort(PORT_L) | onlyPort(PORT_N) | onlyPort(PORT_S);
    cycle();
    cycle();
    expectGrantStep(PORT_L);
    expectGrantStep(PORT_N);
    expectGrantStep(PORT_S);
    expectGrantStep(PORT_L);
    expectGrantStep(PORT_N);
    releaseAll();
    inReq = onlyPort(PORT_N); // A lone requester drops back through idle.
    cycle();
    cycle();
    expectGrantStep(PORT_N);
    expectGrantStep(-1);
    expectGrantStep(PORT_N);
    releaseAll();
    endTest();

    startTest("early release");
    inFlit[PORT_E] = makeFlit(FLIT_HEAD, 13'd100);
    inReq = onlyPort(PORT_E) | onlyPort(PORT_S);
    cycle();
    inFlit[PORT_E] = makeFlit(FLIT_BODY, 13'($urandom));
    cycle();
    repeat (3) expectGrantStep(PORT_E);
    inReq[PORT_E] = 1'b0;
    expectGrantStep(PORT_E);
    expectGrantStep(PORT_E);
    expectGrantStep(PORT_S);
    releaseAll();
    endTest();

    startTest("data path");
    validSeen = 0;
    headSeen = 0;
    bodySeen = 0;
    repeat (80)
    begin
      inReq = 5'($urandom);
      for (int i = 0; i < NUM_PORTS; i++)
        inFlit[i] = randomFlit();
      cycle();
      if (outValid)
        validSeen++;
      if (outValid && outFlit[FLIT_W-1 -: ID_W] == FLIT_HEAD)
        headSeen++;
      if (outValid && outFlit[FLIT_W-1 -: ID_W] == FLIT_BODY)
        bodySeen++;
    end
    if (validSeen == 0 || headSeen == 0 || bodySeen == 0)
      stateError("header and body flits did not both reach the output");
    releaseAll();
    endTest();

    $display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed,
             procErrors + checkErrors);
    if (procErrors + checkErrors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: nocSwitch.sv
module nocSwitch
(
  input logic clk,
  input logic rst,
  input logic [nocPkg::NUM_PORTS-1:0][nocPkg::FLIT_W-1:0] inFlit,
  input logic [nocPkg::NUM_PORTS-1:0] inReq,
  output logic [nocPkg::FLIT_W-1:0] outFlit,
  output logic outValid,
  output logic [nocPkg::NUM_PORTS-1:0] grant
);

  import nocPkg::*;

  portIf link [NUM_PORTS] ();

  portVec_t req;
  portVec_t runTimer;
  portVec_t timesUp;
  portVec_t grantVec;
  flitWord_t xbarFlit;

  // One input register and one hold timer per direction.
  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : gPort
    inputPort inPort
    (
      .clk(clk),
      .rst(rst),
      .linkFlit(inFlit[i]),
      .linkReq(inReq[i]),
      .port(link[i])
    );

    portTimer timer
    (
      .clk(clk),
      .rst(rst),
      .flitId(link[i].flitId),
      .length(link[i].length),
      .runTimer(runTimer[i]),
      .timesUp(timesUp[i])
    );

    assign req[i] = link[i].req;
  end

  switchArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .timesUp(timesUp),
    .runTimer(runTimer),
    .grant(grantVec)
  );

  crossbarMux xbar
  (
    .clk(clk),
    .rst(rst),
    .grant(grantVec),
    .ports(link),
    .outFlit(xbarFlit),
    .outValid(outValid)
  );

  assign outFlit = xbarFlit;
  assign grant = grantVec;

endmodule

// File: crossbarMux.sv
module crossbarMux
(
  input logic clk,
  input logic rst,
  input nocPkg::portVec_t grant,
  portIf.consumer ports [nocPkg::NUM_PORTS],
  output nocPkg::flitWord_t outFlit,
  output logic outValid
);

  import nocPkg::*;

  flitWord_t portFlit [NUM_PORTS];
  flitWord_t selFlit;

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : gFlit
    assign portFlit[i] = ports[i].flit;
  end

  // Grant is one-hot, so at most one port matches.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i])
        selFlit = portFlit[i];
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |grant; // Strobe only, no back-pressure.
  end

endmodule

// File: switchArbiter.sv
module switchArbiter
(
  input logic clk,
  input logic rst,
  input nocPkg::portVec_t req,
  input nocPkg::portVec_t timesUp,
  output nocPkg::portVec_t runTimer,
  output nocPkg::portVec_t grant
);

  import nocPkg::*;

  // Bit 0 is idle, bit i+1 is port i.
  localparam int STATE_W = NUM_PORTS + 1;
  localparam logic [STATE_W-1:0] IDLE_STATE = 1;

  logic [STATE_W-1:0] state;
  logic [STATE_W-1:0] nextState;

  // First requester at or after start, with wraparound.
  function automatic logic [STATE_W-1:0] pickFrom(portVec_t cand, int start);
    logic [STATE_W-1:0] pick;
    int idx;
    pick = IDLE_STATE;
    // Walk backwards so the earliest port in the rotation wins.
    for (int k = NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (start + k) % NUM_PORTS;
      if (cand[idx])
      begin
        pick = '0;
        pick[idx + 1] = 1'b1;
      end
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE_STATE;
    else
      state <= nextState;
  end

  always_comb
  begin
    portVec_t others;
    others = '0;
    nextState = IDLE_STATE; // Also recovers from a broken state.
    runTimer = '0;
    if (state[0])
    begin
      // Fixed order L, N, E, W, S out of idle.
      nextState = pickFrom(req, PORT_L);
    end
    else
    begin
      for (int x = 0; x < NUM_PORTS; x++)
      begin
        if (state[x + 1])
        begin
          if (req[x] && !timesUp[x])
          begin
            // Holder keeps the switch while its time lasts.
            nextState = state;
            runTimer[x] = 1'b1;
          end
          else
          begin
            // Yielding port is skipped in this round.
            others = req;
            others[x] = 1'b0;
            nextState = pickFrom(others, (x + 1) % NUM_PORTS);
          end
        end
      end
    end
  end

  assign grant = state[STATE_W-1:1];

endmodule

// File: portTimer.sv
module portTimer
(
  input logic clk,
  input logic rst,
  input logic [nocPkg::ID_W-1:0] flitId,
  input logic [nocPkg::LEN_W-1:0] length,
  input logic runTimer,
  output logic timesUp
);

  import nocPkg::*;

  logic [LEN_W-1:0] limit;
  logic [LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == FLIT_HEAD)
        limit <= length; // New packet, new hold limit.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // A zero limit still gives the holder one cycle.
  assign timesUp = (count == limit);

endmodule

// File: inputPort.sv
module inputPort
(
  input logic clk,
  input logic rst,
  input nocPkg::flitWord_t linkFlit,
  input logic linkReq,
  portIf.producer port
);

  import nocPkg::*;

  flitWord_t flitReg;
  logic reqReg;

  // Single register stage per link.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitReg <= '0;
      reqReg <= 1'b0;
    end
    else
    begin
      flitReg <= linkFlit;
      reqReg <= linkReq;
    end
  end

  // The id sits in the same bits in both views.
  assign port.flitId = flitReg.body.id;

  // Length is only valid when the id says header.
  assign port.length = flitReg.head.length;

  assign port.req = reqReg;
  assign port.flit = flitReg; // Whole word goes on to the crossbar.

endmodule

// File: portIf.sv
interface portIf;

  import nocPkg::*;

  logic req;                  // Request level from the link.
  logic [ID_W-1:0] flitId;
  logic [LEN_W-1:0] length;   // Only meaningful on a header.
  flitWord_t flit;

  modport producer
  (
    output req,
    output flitId,
    output length,
    output flit
  );

  modport consumer
  (
    input req,
    input flitId,
    input length,
    input flit
  );

endinterface

// File: nocPkg.sv
package nocPkg;

  // Flit format widths.
  localparam int FLIT_W = 16;
  localparam int ID_W = 3;
  localparam int LEN_W = 12;

  localparam int NUM_PORTS = 5;

  // Flit id codes, carried in the top bits of every word.
  localparam logic [ID_W-1:0] FLIT_IDLE = 3'd0;
  localparam logic [ID_W-1:0] FLIT_HEAD = 3'd1;
  localparam logic [ID_W-1:0] FLIT_BODY = 3'd2;
  localparam logic [ID_W-1:0] FLIT_TAIL = 3'd3;

  // Bit positions in request and grant vectors.
  localparam int PORT_L = 0;
  localparam int PORT_N = 1;
  localparam int PORT_E = 2;
  localparam int PORT_W = 3;
  localparam int PORT_S = 4;

  // One flit word, read as a header or as a body flit.
  typedef union packed {
    struct packed {
      logic [ID_W-1:0] id;
      logic spare;
      logic [LEN_W-1:0] length; // Hold limit for the switch.
    } head;
    struct packed {
      logic [ID_W-1:0] id;
      logic [FLIT_W-ID_W-1:0] payload;
    } body;
  } flitWord_t;

  // One bit per port.
  typedef logic [NUM_PORTS-1:0] portVec_t;

endpackage
